// ==== Makefile ====
# Verilator flow for the rename slice.
TOP := rename_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

// ==== project.f ====
+incdir+source
source/rename_pkg.sv
source/lane_config.sv
source/rename_map.sv
source/rename_dispatch_reg.sv
source/rename_top.sv
sim/rename_props.sv
sim/rename_tb.sv

// ==== sim/rename_props.sv ====
// assertions on the rename slice, bound to the top level.
// the stall check lets a flush or a lane-mask write change the outputs.

`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_props
  import rename_pkg::*;
(
  input logic                            clk,
  input logic                            reset_i,
  input logic                            stall_i,
  input logic                            flush_i,
  input logic                            cfg_we_i,
  input lane_mask_t                      dis_valid_o,
  input lane_mask_t                      dis_dest_valid_o,
  input phys_reg_t [`DISPATCH_WIDTH-1:0] dis_src1_o,
  input phys_reg_t [`DISPATCH_WIDTH-1:0] dis_src2_o,
  input phys_reg_t [`DISPATCH_WIDTH-1:0] dis_dest_o
);

  // nothing survives a flush edge.
  flush_clears: assert property (@(posedge clk) disable iff (reset_i)
    flush_i |=> (dis_valid_o == '0))
    else $error("dis_valid_o set in the cycle after a flush");

  stall_holds: assert property (@(posedge clk) disable iff (reset_i)
    (stall_i && !flush_i && !cfg_we_i) |=> (flush_i || ($stable(dis_valid_o)
      && $stable(dis_src1_o) && $stable(dis_src2_o) && $stable(dis_dest_o))))
    else $error("dispatch outputs changed across a stall");

  dest_unique: assert property (@(posedge clk) disable iff (reset_i)
    (&dis_dest_valid_o) |-> (dis_dest_o[0] != dis_dest_o[1]))
    else $error("both lanes carry the same physical destination");  // free list handed one out twice.

endmodule

bind rename_top rename_props u_props (
  .clk              (clk),
  .reset_i          (reset_i),
  .stall_i          (stall_i),
  .flush_i          (flush_i),
  .cfg_we_i         (cfg_we_i),
  .dis_valid_o      (dis_valid_o),
  .dis_dest_valid_o (dis_dest_valid_o),
  .dis_src1_o       (dis_src1_o),
  .dis_src2_o       (dis_src2_o),
  .dis_dest_o       (dis_dest_o)
);

// ==== sim/rename_tb.sv ====
// testbench for the two-lane rename slice.
// each table row is checked one cycle after it is applied, with the next row on the inputs.
// the drain phase starts its free-list model from the state that the table leaves.

`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_tb
  import rename_pkg::*;
();

  typedef struct packed {
    logic [2:0]                      ctl;       // bundle valid, stall, flush.
    arch_reg_t [`DISPATCH_WIDTH-1:0] src1;
    arch_reg_t [`DISPATCH_WIDTH-1:0] src2;
    arch_reg_t [`DISPATCH_WIDTH-1:0] dest;
    lane_mask_t                      dv;
    logic [2:0]                      cfg;       // write enable, then the lane mask.
    logic [6:0]                      free_ret;  // strobe, then the returned register.
    lane_mask_t                      exp_valid;
    phys_reg_t [`DISPATCH_WIDTH-1:0] exp_src1;
    phys_reg_t [`DISPATCH_WIDTH-1:0] exp_src2;
    phys_reg_t [`DISPATCH_WIDTH-1:0] exp_dest;
  } row_t;

  logic                            clk;
  logic                            reset_i;
  logic                            bundle_valid_i, stall_i, flush_i;
  logic                            free_valid_i, cfg_we_i;
  logic                            ready_o;
  arch_reg_t [`DISPATCH_WIDTH-1:0] src1_i, src2_i, dest_i;
  lane_mask_t                      dest_valid_i, cfg_lane_active_i;
  phys_reg_t                       free_reg_i;
  lane_mask_t                      dis_valid_o, dis_dest_valid_o;
  phys_reg_t [`DISPATCH_WIDTH-1:0] dis_src1_o, dis_src2_o, dis_dest_o;

  row_t      rows [16];
  int        n_rows;
  int        errors;
  int        timeouts;
  integer    seed;
  phys_reg_t free_model [$];  // expected allocation order in the drain phase.

  rename_top u_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic add_row(input logic [2:0] ctl, input arch_reg_t [`DISPATCH_WIDTH-1:0] s1,
                         input arch_reg_t [`DISPATCH_WIDTH-1:0] s2,
                         input arch_reg_t [`DISPATCH_WIDTH-1:0] d, input lane_mask_t dv,
                         input logic [2:0] cfg, input logic [6:0] fr, input lane_mask_t ev,
                         input phys_reg_t [`DISPATCH_WIDTH-1:0] e1,
                         input phys_reg_t [`DISPATCH_WIDTH-1:0] e2,
                         input phys_reg_t [`DISPATCH_WIDTH-1:0] ed);
    rows[n_rows] = {ctl, s1, s2, d, dv, cfg, fr, ev, e1, e2, ed};
    n_rows++;
  endtask

  task automatic drive_row(input row_t r);
    bundle_valid_i    <= r.ctl[2];
    stall_i           <= r.ctl[1];
    flush_i           <= r.ctl[0];
    src1_i            <= r.src1;
    src2_i            <= r.src2;
    dest_i            <= r.dest;
    dest_valid_i      <= r.dv;
    cfg_we_i          <= r.cfg[2];
    cfg_lane_active_i <= r.cfg[1:0];
    free_valid_i      <= r.free_ret[6];
    free_reg_i        <= r.free_ret[5:0];
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_mask(input string name, input lane_mask_t exp, input lane_mask_t act);
    if (act !== exp)
    begin
      $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input phys_reg_t exp, input phys_reg_t act);
    if (act !== exp)
    begin
      $display("error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_row(input row_t r);
    check_mask("dis_valid_o", r.exp_valid, dis_valid_o);
    for (int l = 0; l < `DISPATCH_WIDTH; l++)
    begin
      check_reg($sformatf("dis_src1_o[%0d]", l), r.exp_src1[l], dis_src1_o[l]);
      check_reg($sformatf("dis_src2_o[%0d]", l), r.exp_src2[l], dis_src2_o[l]);
      check_reg($sformatf("dis_dest_o[%0d]", l), r.exp_dest[l], dis_dest_o[l]);
    end
  endtask

  // returns at the first falling edge where ready_o is high.
  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (ready_o !== 1'b1 && n < limit);
    if (ready_o !== 1'b1)
    begin
      $display("timeout: ready_o stayed low for %0d cycles", limit);
      timeouts++;
    end
  endtask

  task automatic issue_bundle(input lane_mask_t dv);
    int        rnd;
    phys_reg_t want;
    @(posedge clk);
    rnd = $random(seed);
    bundle_valid_i <= 1'b1;
    dest_i         <= {rnd[12:8], rnd[4:0]};
    dest_valid_i   <= dv;
    wait_ready(20);
    @(posedge clk);  // accepting edge.
    bundle_valid_i <= 1'b0;
    @(negedge clk);
    check_mask("dis_valid_o", 2'b11, dis_valid_o);
    check_mask("dis_dest_valid_o", dv, dis_dest_valid_o);
    for (int l = 0; l < `DISPATCH_WIDTH; l++)
    begin
      if (dv[l])
      begin
        want = free_model.pop_front();
        check_reg($sformatf("dis_dest_o[%0d]", l), want, dis_dest_o[l]);
      end
    end
  endtask

  initial
  begin
    seed     = 80;
    errors   = 0;
    timeouts = 0;
    n_rows   = 0;
    reset_i  <= 1'b1;
    drive_row('0);
    // lane pairs are written {lane 1, lane 0}.
    add_row(3'b100, {5'd2, 5'd1}, {5'd6, 5'd5}, {5'd4, 5'd3}, 2'b11, 3'b000, 7'd0,
            2'b11, {6'd2, 6'd1}, {6'd6, 6'd5}, {6'd33, 6'd32});
    add_row(3'b100, {5'd4, 5'd3}, {5'd3, 5'd4}, {5'd8, 5'd7}, 2'b11, 3'b000, 7'd0,
            2'b11, {6'd33, 6'd32}, {6'd32, 6'd33}, {6'd35, 6'd34});
    add_row(3'b100, {5'd9, 5'd7}, {5'd8, 5'd0}, {5'd10, 5'd9}, 2'b11, 3'b000, 7'd0,
            2'b11, {6'd36, 6'd34}, {6'd35, 6'd0}, {6'd37, 6'd36});  // lane 1 reads r9 bypassed.
    // this write asks for no lanes at all, so only lane 1 turns off.
    add_row(3'b000, '0, '0, '0, 2'b00, 3'b100, 7'd0, 2'b00, '0, '0, '0);
    add_row(3'b100, {5'd3, 5'd10}, {5'd4, 5'd9}, {5'd12, 5'd11}, 2'b11, 3'b000, 7'd0,
            2'b01, {6'd0, 6'd37}, {6'd0, 6'd36}, {6'd0, 6'd38});
    add_row(3'b000, '0, '0, '0, 2'b00, 3'b111, 7'd0, 2'b00, '0, '0, '0);
    add_row(3'b100, {5'd12, 5'd11}, {5'd13, 5'd12}, {5'd14, 5'd13}, 2'b11, 3'b000, 7'd0,
            2'b11, {6'd12, 6'd38}, {6'd39, 6'd12}, {6'd40, 6'd39});
    add_row(3'b110, {5'd2, 5'd1}, '0, {5'd16, 5'd15}, 2'b11, 3'b000, 7'd0,
            2'b11, {6'd12, 6'd38}, {6'd39, 6'd12}, {6'd40, 6'd39});
    add_row(3'b100, {5'd1, 5'd14}, {5'd14, 5'd2}, {5'd16, 5'd15}, 2'b11, 3'b000, 7'd0,
            2'b11, {6'd1, 6'd40}, {6'd40, 6'd2}, {6'd42, 6'd41});
    add_row(3'b010, '0, '0, '0, 2'b00, 3'b000, 7'd0, 2'b00, '0, '0, '0);
    add_row(3'b101, {5'd1, 5'd2}, '0, {5'd20, 5'd19}, 2'b11, 3'b000, 7'd0,
            2'b00, '0, '0, '0);
    add_row(3'b000, '0, '0, '0, 2'b00, 3'b000, {1'b1, 6'd3}, 2'b00, '0, '0, '0);
    add_row(3'b100, {5'd16, 5'd15}, '0, {5'd18, 5'd17}, 2'b10, 3'b000, 7'd0,
            2'b11, {6'd42, 6'd41}, '0, {6'd43, 6'd0});

    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    check_mask("dis_valid_o", 2'b00, dis_valid_o);
    check_bit("ready_o", 1'b1, ready_o);

    for (int i = 0; i <= n_rows; i++)
    begin
      @(posedge clk);
      if (i < n_rows)
        drive_row(rows[i]);
      else
        drive_row('0);
      @(negedge clk);
      if (i > 0)
        check_row(rows[i-1]);
    end

    // registers 32 to 43 went out in the table, and r3's old register came back last.
    for (int r = 44; r < 64; r++)
      free_model.push_back(phys_reg_t'(r));
    free_model.push_back(6'd3);
    while (free_model.size() > 0)
      issue_bundle(free_model.size() > 1 ? 2'b11 : 2'b01);

    @(posedge clk);
    bundle_valid_i <= 1'b1;
    dest_valid_i   <= 2'b01;
    repeat (3)
    begin
      @(negedge clk);
      check_bit("ready_o", 1'b0, ready_o);
      check_mask("dis_valid_o", 2'b00, dis_valid_o);
    end
    @(posedge clk);
    free_valid_i <= 1'b1;
    free_reg_i   <= 6'd5;
    free_model.push_back(6'd5);
    @(posedge clk);
    free_valid_i <= 1'b0;
    wait_ready(20);
    @(posedge clk);
    bundle_valid_i <= 1'b0;
    @(negedge clk);
    check_mask("dis_valid_o", 2'b11, dis_valid_o);
    check_reg("dis_dest_o[0]", free_model.pop_front(), dis_dest_o[0]);

    $display("checks done, errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== source/lane_config.sv ====
// lane-active mask for the rename slice.
// lane 0 is always kept on, whatever the configuration write asks for.

`timescale 1ns/1ps

`include "rename_settings.svh"

module lane_config
  import rename_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  logic       cfg_we_i,
  input  lane_mask_t cfg_lane_active_i,
  output lane_mask_t lane_active_o
);

  lane_mask_t active_q;

  // every lane comes out of reset enabled.
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      active_q <= '1;
    end
    else if (cfg_we_i)
    begin
      active_q <= {cfg_lane_active_i[`DISPATCH_WIDTH-1:1], 1'b1};  // lane 0 stays on.
    end
  end

  assign lane_active_o = active_q;  // new mask is seen the cycle after the write.

endmodule

// ==== source/rename_dispatch_reg.sv ====
// pipeline register between rename and dispatch.
// fields of an inactive lane read as zero, as an isolation cell would give.
// during a flush every lane reads as zero, before the register itself clears.

`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_dispatch_reg
  import rename_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             stall_i,
  input  logic                             flush_i,
  input  lane_mask_t                       lane_active_i,
  input  lane_mask_t                       ren_valid_i,
  input  lane_mask_t                       phy_dest_valid_i,
  input  phys_reg_t [`DISPATCH_WIDTH-1:0]  phy_src1_i,
  input  phys_reg_t [`DISPATCH_WIDTH-1:0]  phy_src2_i,
  input  phys_reg_t [`DISPATCH_WIDTH-1:0]  phy_dest_i,
  output lane_mask_t                       dis_valid_o,
  output lane_mask_t                       dis_dest_valid_o,
  output phys_reg_t [`DISPATCH_WIDTH-1:0]  dis_src1_o,
  output phys_reg_t [`DISPATCH_WIDTH-1:0]  dis_src2_o,
  output phys_reg_t [`DISPATCH_WIDTH-1:0]  dis_dest_o
);

  lane_mask_t                      valid_q;
  lane_mask_t                      dest_valid_q;
  phys_reg_t [`DISPATCH_WIDTH-1:0] src1_q;
  phys_reg_t [`DISPATCH_WIDTH-1:0] src2_q;
  phys_reg_t [`DISPATCH_WIDTH-1:0] dest_q;

  always_ff @(posedge clk)
  begin
    if (reset_i || flush_i)
    begin
      valid_q      <= '0;
      dest_valid_q <= '0;
      src1_q       <= '0;
      src2_q       <= '0;
      dest_q       <= '0;
    end
    else if (!stall_i)  // hold the whole bundle while dispatch is busy.
    begin
      valid_q      <= ren_valid_i;
      dest_valid_q <= phy_dest_valid_i;
      src1_q       <= phy_src1_i;
      src2_q       <= phy_src2_i;
      dest_q       <= phy_dest_i;
    end
  end

  // per-lane output isolation.
  always_comb
  begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
    begin
      if (!lane_active_i[i] || flush_i)
      begin
        dis_valid_o[i]      = 1'b0;
        dis_dest_valid_o[i] = 1'b0;
        dis_src1_o[i]       = '0;
        dis_src2_o[i]       = '0;
        dis_dest_o[i]       = '0;
      end
      else
      begin
        dis_valid_o[i]      = valid_q[i];
        dis_dest_valid_o[i] = dest_valid_q[i];
        dis_src1_o[i]       = src1_q[i];
        dis_src2_o[i]       = src2_q[i];
        dis_dest_o[i]       = dest_q[i];
      end
    end
  end

endmodule

// ==== source/rename_map.sv ====
// map table and free list for the two-lane rename stage.
// the free list never overflows, because only registers handed out earlier are returned.
// there is no checkpoint, so a flush leaves the map as the last accepted bundle wrote it.
// a freed register becomes allocatable one cycle after its strobe.

`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_map
  import rename_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             bundle_valid_i,
  input  logic                             stall_i,
  input  logic                             flush_i,
  input  lane_mask_t                       lane_active_i,
  input  arch_reg_t [`DISPATCH_WIDTH-1:0]  src1_i,
  input  arch_reg_t [`DISPATCH_WIDTH-1:0]  src2_i,
  input  arch_reg_t [`DISPATCH_WIDTH-1:0]  dest_i,
  input  lane_mask_t                       dest_valid_i,
  input  logic                             free_valid_i,
  input  phys_reg_t                        free_reg_i,
  output lane_mask_t                       ren_valid_o,
  output phys_reg_t [`DISPATCH_WIDTH-1:0]  phy_src1_o,
  output phys_reg_t [`DISPATCH_WIDTH-1:0]  phy_src2_o,
  output phys_reg_t [`DISPATCH_WIDTH-1:0]  phy_dest_o,
  output lane_mask_t                       phy_dest_valid_o,
  output logic                             ready_o
);

  localparam int PTR_W = $clog2(`FREE_DEPTH);

  phys_reg_t                       map_q [`ARCH_REGS];
  phys_reg_t                       free_mem [`FREE_DEPTH];
  logic [PTR_W-1:0]                head_q;
  logic [PTR_W-1:0]                tail_q;
  logic [PTR_W-1:0]                alloc_head;  // head after this bundle's pops.
  free_count_t                     count_q;
  free_count_t                     need_cnt;
  free_count_t                     pop_cnt;
  lane_mask_t                      need;
  phys_reg_t [`DISPATCH_WIDTH-1:0] alloc_reg;
  logic                            accept;

  assign need    = lane_active_i & dest_valid_i;  // lanes that want a new register.
  assign ready_o = (count_q >= need_cnt);
  assign accept  = bundle_valid_i & ~stall_i & ~flush_i & ready_o;
  assign pop_cnt = accept ? need_cnt : '0;

  // walk the lanes in order and hand out entries from the head.
  always_comb
  begin
    alloc_head = head_q;
    need_cnt   = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
    begin
      alloc_reg[i] = free_mem[alloc_head];
      if (need[i])
      begin
        alloc_head = alloc_head + PTR_W'(1);  // wraps at the list depth.
        need_cnt   = need_cnt + free_count_t'(1);
      end
    end
  end

  // source lookup. an older lane's destination in the same bundle wins over the table.
  always_comb
  begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
    begin
      phy_src1_o[i] = map_q[src1_i[i]];
      phy_src2_o[i] = map_q[src2_i[i]];
      for (int j = 0; j < i; j++)
      begin
        if (need[j] && (dest_i[j] == src1_i[i]))
        begin
          phy_src1_o[i] = alloc_reg[j];
        end
        if (need[j] && (dest_i[j] == src2_i[i]))
        begin
          phy_src2_o[i] = alloc_reg[j];
        end
      end
      phy_dest_o[i] = need[i] ? alloc_reg[i] : '0;
    end
  end

  assign ren_valid_o      = lane_active_i & {`DISPATCH_WIDTH{accept}};
  assign phy_dest_valid_o = need & {`DISPATCH_WIDTH{accept}};

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      // identity map, and the upper half of the register file queued in order.
      for (int r = 0; r < `ARCH_REGS; r++)
      begin
        map_q[r] <= phys_reg_t'(r);
      end
      for (int k = 0; k < `FREE_DEPTH; k++)
      begin
        free_mem[k] <= phys_reg_t'(`ARCH_REGS + k);
      end
      head_q  <= '0;
      tail_q  <= '0;  // full list, so tail meets head.
      count_q <= free_count_t'(`FREE_DEPTH);
    end
    else
    begin
      if (accept)
      begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++)
        begin
          if (need[i])
          begin
            map_q[dest_i[i]] <= alloc_reg[i];  // a later lane overrides an earlier one.
          end
        end
        head_q <= alloc_head;
      end
      if (free_valid_i)
      begin
        free_mem[tail_q] <= free_reg_i;
        tail_q           <= tail_q + PTR_W'(1);
      end
      count_q <= count_q - pop_cnt + free_count_t'(free_valid_i);
    end
  end

endmodule

// ==== source/rename_pkg.sv ====
// types shared by the rename slice.
// every width here comes from the register counts in the settings header.

`include "rename_settings.svh"

package rename_pkg;

  // index into the architectural register file, 5 bits.
  typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

  // index into the physical register file, 6 bits.
  typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;

  typedef logic [`DISPATCH_WIDTH-1:0] lane_mask_t;  // one bit per lane.

  // free-list occupancy from empty up to full.
  // one extra bit over the pointer width so that a full list reads as 32.
  typedef logic [$clog2(`FREE_DEPTH + 1)-1:0] free_count_t;

endpackage

// ==== source/rename_settings.svh ====
// fixed sizes for the two-lane rename slice.
// the free list holds every physical register that the identity map leaves over.
// FREE_DEPTH must stay a power of two so that the free-list pointers wrap naturally.

`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// number of rename lanes per bundle.
`define DISPATCH_WIDTH 2

`define ARCH_REGS 32   // architectural registers.
`define PHYS_REGS 64   // physical registers.

// registers not covered by the reset map start out free.
`define FREE_DEPTH (`PHYS_REGS - `ARCH_REGS)

`endif

// ==== source/rename_top.sv ====
// two-lane rename slice from architectural registers to the dispatch register.
// ready_o is combinational and only says whether enough free registers remain.

`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_top
  import rename_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             bundle_valid_i,
  input  arch_reg_t [`DISPATCH_WIDTH-1:0]  src1_i,
  input  arch_reg_t [`DISPATCH_WIDTH-1:0]  src2_i,
  input  arch_reg_t [`DISPATCH_WIDTH-1:0]  dest_i,
  input  lane_mask_t                       dest_valid_i,
  input  logic                             stall_i,
  input  logic                             flush_i,
  input  logic                             free_valid_i,
  input  phys_reg_t                        free_reg_i,
  input  logic                             cfg_we_i,
  input  lane_mask_t                       cfg_lane_active_i,
  output logic                             ready_o,
  output lane_mask_t                       dis_valid_o,
  output lane_mask_t                       dis_dest_valid_o,
  output phys_reg_t [`DISPATCH_WIDTH-1:0]  dis_src1_o,
  output phys_reg_t [`DISPATCH_WIDTH-1:0]  dis_src2_o,
  output phys_reg_t [`DISPATCH_WIDTH-1:0]  dis_dest_o
);

  lane_mask_t                      lane_active;
  lane_mask_t                      ren_valid;
  lane_mask_t                      phy_dest_valid;
  phys_reg_t [`DISPATCH_WIDTH-1:0] phy_src1;
  phys_reg_t [`DISPATCH_WIDTH-1:0] phy_src2;
  phys_reg_t [`DISPATCH_WIDTH-1:0] phy_dest;

  lane_config u_lane_config (
    .clk               (clk),
    .reset_i           (reset_i),
    .cfg_we_i          (cfg_we_i),
    .cfg_lane_active_i (cfg_lane_active_i),
    .lane_active_o     (lane_active)
  );

  // the same lane mask gates allocation and output isolation.
  rename_map u_rename_map (
    .clk              (clk),
    .reset_i          (reset_i),
    .bundle_valid_i   (bundle_valid_i),
    .stall_i          (stall_i),
    .flush_i          (flush_i),
    .lane_active_i    (lane_active),
    .src1_i           (src1_i),
    .src2_i           (src2_i),
    .dest_i           (dest_i),
    .dest_valid_i     (dest_valid_i),
    .free_valid_i     (free_valid_i),
    .free_reg_i       (free_reg_i),
    .ren_valid_o      (ren_valid),
    .phy_src1_o       (phy_src1),
    .phy_src2_o       (phy_src2),
    .phy_dest_o       (phy_dest),
    .phy_dest_valid_o (phy_dest_valid),
    .ready_o          (ready_o)
  );

  rename_dispatch_reg u_dispatch_reg (
    .clk              (clk),
    .reset_i          (reset_i),
    .stall_i          (stall_i),
    .flush_i          (flush_i),
    .lane_active_i    (lane_active),
    .ren_valid_i      (ren_valid),
    .phy_dest_valid_i (phy_dest_valid),
    .phy_src1_i       (phy_src1),
    .phy_src2_i       (phy_src2),
    .phy_dest_i       (phy_dest),
    .dis_valid_o      (dis_valid_o),
    .dis_dest_valid_o (dis_dest_valid_o),
    .dis_src1_o       (dis_src1_o),
    .dis_src2_o       (dis_src2_o),
    .dis_dest_o       (dis_dest_o)
  );

endmodule
